//--- source/ling_pkg.sv
// Widths are fixed at 18 bits because the prefix tree wiring in ling_prefix_tree is written for them
`default_nettype none

package ling_pkg;

	// Operand and result width
	localparam int WIDTH = 18;

	// Propagate and generate vectors, bit 0 holds the carry in
	localparam int PG_WIDTH = WIDTH + 1;

	// Operation codes presented with op_valid
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_ACC = 2'd2,
		OP_CLR = 2'd3
	} opcode_t;

	// Operand conditioning, decoded from the opcode
	typedef struct packed {
		// First operand comes from the accumulator
		logic use_acc;
		// Second operand is complemented
		logic invert_b;
		// Carry in is one whatever the caller drives
		logic force_cin;
		// Add collapses to zero, the second operand is dropped along with the first
		logic zero_a;
	} prep_ctrl_t;

	// Pre-computed OR propagate and AND generate
	typedef struct packed {
		logic [PG_WIDTH-1:0] p;
		logic [PG_WIDTH-1:0] g;
	} pg_t;

	// Tree outputs, index k belongs to vector position k+1
	typedef struct packed {
		// Ling pseudo-carries out of each position
		logic [WIDTH-1:0] h;
		// True carries into each position
		logic [WIDTH-1:0] c;
	} ling_t;

	typedef struct packed {
		logic cout;
		logic ovf;
		logic zero;
		logic neg;
	} flags_t;

	typedef struct packed {
		logic [WIDTH-1:0] sum;
		flags_t           flags;
	} result_t;

endpackage

`default_nettype wire

//--- source/ling_operand_prep.sv
// Purely combinational; the carry in from the caller only counts for the plain add
`default_nettype none

module ling_operand_prep (
	input  wire logic [ling_pkg::WIDTH-1:0] op_a,
	input  wire logic [ling_pkg::WIDTH-1:0] op_b,
	input  wire logic                       cin,
	input  wire logic [ling_pkg::WIDTH-1:0] acc,
	input  wire ling_pkg::prep_ctrl_t       prep,
	output ling_pkg::pg_t                   pg,
	output logic                            sign_a,
	output logic                            sign_b
);

	logic [ling_pkg::WIDTH-1:0] opnd_a;
	logic [ling_pkg::WIDTH-1:0] opnd_b;
	logic                       cin_eff;

	always_comb begin
		// First operand select
		if (prep.zero_a)
			opnd_a = '0;
		else if (prep.use_acc)
			opnd_a = acc;
		else
			opnd_a = op_a;

		// Second operand, complemented for subtract
		if (prep.zero_a)
			opnd_b = '0;
		else
			opnd_b = op_b ^ {ling_pkg::WIDTH{prep.invert_b}};

		// Accumulate and clear drop the caller's carry
		cin_eff = prep.force_cin | (cin & ~(prep.use_acc | prep.zero_a));
	end

	// Bit 0 of p is tied high so the carry in passes through the tree
	assign pg = '{p: {opnd_a | opnd_b, 1'b1}, g: {opnd_a & opnd_b, cin_eff}};

	assign sign_a = opnd_a[ling_pkg::WIDTH-1];
	assign sign_b = opnd_b[ling_pkg::WIDTH-1];

endmodule

`default_nettype wire

//--- source/ling_prefix_tree.sv
// Han-Carlson tree for exactly 18 bits plus carry in; cells use the Ling shifted propagate
`default_nettype none

module ling_prefix_tree (
	input  wire ling_pkg::pg_t pg,
	output ling_pkg::ling_t    lc
);

	// Reduced grey cell, first stage next to the carry in
	function automatic logic rgry(input logic g_hi, input logic g_lo);
		return g_hi | g_lo;
	endfunction

	// Reduced black cell, returns {h, i}
	function automatic logic [1:0] rblk(input logic g_hi, input logic g_lo,
			input logic p_hi, input logic p_lo);
		return {g_hi | g_lo, p_hi & p_lo};
	endfunction

	// Black cell, returns {h, i}
	function automatic logic [1:0] black(input logic h_hi, input logic h_lo,
			input logic i_hi, input logic i_lo);
		return {h_hi | (i_hi & h_lo), i_hi & i_lo};
	endfunction

	// Grey cell, only the pseudo-carry survives
	function automatic logic grey(input logic h_hi, input logic h_lo, input logic i_hi);
		return h_hi | (i_hi & h_lo);
	endfunction

	logic [ling_pkg::PG_WIDTH-1:0] p;
	logic [ling_pkg::PG_WIDTH-1:0] g;

	// Stage 1 spans
	logic h_1_0, h_3_2, h_5_4, h_7_6, h_9_8, h_11_10, h_13_12, h_15_14, h_17_16;
	logic i_3_2, i_5_4, i_7_6, i_9_8, i_11_10, i_13_12, i_15_14, i_17_16;
	// Stage 2 spans
	logic h_3_0, h_5_2, h_7_4, h_9_6, h_11_8, h_13_10, h_15_12, h_17_14;
	logic i_5_2, i_7_4, i_9_6, i_11_8, i_13_10, i_15_12, i_17_14;
	// Stage 3 spans
	logic h_5_0, h_7_0, h_9_2, h_11_4, h_13_6, h_15_8, h_17_10;
	logic i_9_2, i_11_4, i_13_6, i_15_8, i_17_10;
	// Stage 4 and 5 spans
	logic h_9_0, h_11_0, h_13_0, h_15_0, h_17_2, h_17_0;
	logic i_17_2;
	// Even positions from the extra grey stage
	logic h_2_0, h_4_0, h_6_0, h_8_0, h_10_0, h_12_0, h_14_0, h_16_0;

	// Pseudo-carries H_k:0 for k = 1 to 17, then true carries
	logic [ling_pkg::WIDTH-2:0] hp;
	logic [ling_pkg::WIDTH-1:0] cv;

	assign p = pg.p;
	assign g = pg.g;

	// Odd positions pair up with their even neighbour
	assign h_1_0 = rgry(g[1], g[0]);
	assign {h_3_2, i_3_2} = rblk(g[3], g[2], p[2], p[1]);
	assign {h_5_4, i_5_4} = rblk(g[5], g[4], p[4], p[3]);
	assign {h_7_6, i_7_6} = rblk(g[7], g[6], p[6], p[5]);
	assign {h_9_8, i_9_8} = rblk(g[9], g[8], p[8], p[7]);
	assign {h_11_10, i_11_10} = rblk(g[11], g[10], p[10], p[9]);
	assign {h_13_12, i_13_12} = rblk(g[13], g[12], p[12], p[11]);
	assign {h_15_14, i_15_14} = rblk(g[15], g[14], p[14], p[13]);
	assign {h_17_16, i_17_16} = rblk(g[17], g[16], p[16], p[15]);

	assign h_3_0 = grey(h_3_2, h_1_0, i_3_2);
	assign {h_5_2, i_5_2} = black(h_5_4, h_3_2, i_5_4, i_3_2);
	assign {h_7_4, i_7_4} = black(h_7_6, h_5_4, i_7_6, i_5_4);
	assign {h_9_6, i_9_6} = black(h_9_8, h_7_6, i_9_8, i_7_6);
	assign {h_11_8, i_11_8} = black(h_11_10, h_9_8, i_11_10, i_9_8);
	assign {h_13_10, i_13_10} = black(h_13_12, h_11_10, i_13_12, i_11_10);
	assign {h_15_12, i_15_12} = black(h_15_14, h_13_12, i_15_14, i_13_12);
	assign {h_17_14, i_17_14} = black(h_17_16, h_15_14, i_17_16, i_15_14);

	assign h_5_0 = grey(h_5_2, h_1_0, i_5_2);
	assign h_7_0 = grey(h_7_4, h_3_0, i_7_4);
	assign {h_9_2, i_9_2} = black(h_9_6, h_5_2, i_9_6, i_5_2);
	assign {h_11_4, i_11_4} = black(h_11_8, h_7_4, i_11_8, i_7_4);
	assign {h_13_6, i_13_6} = black(h_13_10, h_9_6, i_13_10, i_9_6);
	assign {h_15_8, i_15_8} = black(h_15_12, h_11_8, i_15_12, i_11_8);
	assign {h_17_10, i_17_10} = black(h_17_14, h_13_10, i_17_14, i_13_10);

	assign h_9_0 = grey(h_9_2, h_1_0, i_9_2);
	assign h_11_0 = grey(h_11_4, h_3_0, i_11_4);
	assign h_13_0 = grey(h_13_6, h_5_0, i_13_6);
	assign h_15_0 = grey(h_15_8, h_7_0, i_15_8);
	assign {h_17_2, i_17_2} = black(h_17_10, h_9_2, i_17_10, i_9_2);

	assign h_17_0 = grey(h_17_2, h_1_0, i_17_2);

	// Even positions resolve one position past the odd ones
	assign h_2_0 = grey(g[2], h_1_0, p[1]);
	assign h_4_0 = grey(g[4], h_3_0, p[3]);
	assign h_6_0 = grey(g[6], h_5_0, p[5]);
	assign h_8_0 = grey(g[8], h_7_0, p[7]);
	assign h_10_0 = grey(g[10], h_9_0, p[9]);
	assign h_12_0 = grey(g[12], h_11_0, p[11]);
	assign h_14_0 = grey(g[14], h_13_0, p[13]);
	assign h_16_0 = grey(g[16], h_15_0, p[15]);

	assign hp = {h_17_0, h_16_0, h_15_0, h_14_0, h_13_0, h_12_0, h_11_0, h_10_0, h_9_0,
		h_8_0, h_7_0, h_6_0, h_5_0, h_4_0, h_3_0, h_2_0, h_1_0};

	// Carry into position k+1 is p[k] AND H_k:0
	always_comb begin
		cv[0] = g[0];
		for (int k = 1; k < ling_pkg::WIDTH; k++) begin
			cv[k] = p[k] & hp[k-1];
		end
	end

	// Top pseudo-carry folds in the last generate
	assign lc = '{h: {g[ling_pkg::WIDTH] | cv[ling_pkg::WIDTH-1], hp}, c: cv};

endmodule

`default_nettype wire

//--- source/ling_post_compute.sv
// Combinational; overflow uses the operand signs after conditioning, not the caller's inputs
`default_nettype none

module ling_post_compute (
	input  wire ling_pkg::ling_t lc,
	input  wire ling_pkg::pg_t   pg,
	input  wire logic            sign_a,
	input  wire logic            sign_b,
	output ling_pkg::result_t    comb_res
);

	localparam int W = ling_pkg::WIDTH;

	logic [W-1:0]      sum;
	ling_pkg::flags_t  flags;

	// Ling sum rule
	// where a and b are both one, g masks the XOR and the carry passes straight through
	assign sum = (pg.p[W:1] ^ lc.h) | (pg.g[W:1] & lc.c);

	always_comb begin
		// Top pseudo-carry qualified by top propagate gives the real carry out
		flags.cout = pg.p[W] & lc.h[W-1];

		// Same-sign operands with a sum of the other sign
		flags.ovf = (sign_a == sign_b) & (sum[W-1] != sign_a);

		flags.zero = ~|sum;
		flags.neg  = sum[W-1];
	end

	assign comb_res = '{sum: sum, flags: flags};

endmodule

`default_nettype wire

//--- source/ling_alu_ctrl.sv
// Result is held until the next op_valid; there is no back-pressure so a result shows for one cycle
`default_nettype none

module ling_alu_ctrl (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire logic                       op_valid,
	input  wire ling_pkg::opcode_t          op,
	input  wire ling_pkg::result_t          comb_res,
	output ling_pkg::prep_ctrl_t            prep,
	output logic [ling_pkg::WIDTH-1:0]      acc,
	output logic                            res_valid,
	output ling_pkg::result_t               res
);

	// Opcode decode, follows op every cycle
	always_comb begin
		prep = '0;
		unique case (op)
			ling_pkg::OP_ADD: begin
				prep = '0;
			end
			ling_pkg::OP_SUB: begin
				// a + ~b + 1
				prep.invert_b  = 1'b1;
				prep.force_cin = 1'b1;
			end
			ling_pkg::OP_ACC: begin
				prep.use_acc = 1'b1;
			end
			ling_pkg::OP_CLR: begin
				prep.zero_a = 1'b1;
			end
			default: begin
				prep = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			res_valid <= 1'b0;
			res       <= '0;
			acc       <= '0;
		end else begin
			res_valid <= op_valid;
			if (op_valid) begin
				res <= comb_res;
				// Back-to-back accumulates see this write on the next cycle
				if (op == ling_pkg::OP_ACC)
					acc <= comb_res.sum;
				else if (op == ling_pkg::OP_CLR)
					acc <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/ling_alu_top.sv
// One result per op_valid, one cycle later; cin is only used by the plain add
`default_nettype none

module ling_alu_top (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire logic                       op_valid,
	input  wire ling_pkg::opcode_t          op,
	input  wire logic [ling_pkg::WIDTH-1:0] a,
	input  wire logic [ling_pkg::WIDTH-1:0] b,
	input  wire logic                       cin,
	output logic                            res_valid,
	output ling_pkg::result_t               res
);

	ling_pkg::prep_ctrl_t       prep;
	logic [ling_pkg::WIDTH-1:0] acc;
	ling_pkg::pg_t              pg;
	ling_pkg::ling_t            lc;
	ling_pkg::result_t          comb_res;
	logic                       sign_a;
	logic                       sign_b;

	ling_alu_ctrl u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.op_valid  (op_valid),
		.op        (op),
		.comb_res  (comb_res),
		.prep      (prep),
		.acc       (acc),
		.res_valid (res_valid),
		.res       (res)
	);

	// Adder datapath, combinational from operands to comb_res
	ling_operand_prep u_prep (
		.op_a   (a),
		.op_b   (b),
		.cin    (cin),
		.acc    (acc),
		.prep   (prep),
		.pg     (pg),
		.sign_a (sign_a),
		.sign_b (sign_b)
	);

	ling_prefix_tree u_tree (
		.pg (pg),
		.lc (lc)
	);

	ling_post_compute u_post (
		.lc       (lc),
		.pg       (pg),
		.sign_a   (sign_a),
		.sign_b   (sign_b),
		.comb_res (comb_res)
	);

endmodule

`default_nettype wire

//--- tests/ling_alu_props.sv
// Bound into ling_alu_ctrl; assumes one clock and the synchronous active-high reset
`default_nettype none

module ling_alu_props (
	input wire logic              clk,
	input wire logic              rst,
	input wire logic              op_valid,
	input wire logic              res_valid,
	input wire ling_pkg::result_t res
);
	timeunit 1ns;
	timeprecision 100ps;

	// Reset clears strobe and result on the next edge
	reset_state: assert property (@(posedge clk) rst |=> (!res_valid && res == '0))
		else $error("res_valid or res not cleared by reset");

	valid_follows_op: assert property (@(posedge clk) disable iff (rst)
			op_valid |=> res_valid)
		else $error("op_valid not followed by res_valid one cycle later");

	no_spurious_valid: assert property (@(posedge clk) disable iff (rst)
			!op_valid |=> !res_valid)
		else $error("res_valid raised without an operation in the previous cycle");

	zero_flag_matches: assert property (@(posedge clk) disable iff (rst)
			res_valid |-> (res.flags.zero == (res.sum == '0)))
		else $error("zero flag disagrees with the registered sum");

endmodule

`default_nettype wire

//--- tests/ling_alu_checker.sv
// Expectations arrive one cycle ahead of the matching res_valid and are consumed in issue order
`default_nettype none

module ling_alu_checker (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              exp_valid,
	input  wire ling_pkg::result_t exp_res,
	input  wire logic              res_valid,
	input  wire ling_pkg::result_t res,
	input  wire logic              end_check,
	output int                     mismatch_count,
	output int                     protocol_count,
	output int                     checked_count
);
	timeunit 1ns;
	timeprecision 100ps;

	ling_pkg::result_t exp_q[$];
	int                mism = 0;
	int                prot = 0;
	int                seen = 0;

	task automatic compare_field(input string name, input logic [17:0] want,
			input logic [17:0] got);
		if (want !== got) begin
			$display("Mismatch at %0t ns: %s expected 0x%05h actual 0x%05h",
				$time, name, want, got);
			mism++;
		end
	endtask

	always @(posedge clk) begin : check_results
		ling_pkg::result_t want;
		if (!rst && res_valid) begin
			seen++;
			if (exp_q.size() == 0) begin
				$display("Error at %0t ns: res_valid raised with no operation outstanding", $time);
				prot++;
			end else begin
				want = exp_q.pop_front();
				compare_field("res.sum", want.sum, res.sum);
				compare_field("res.flags.cout", 18'(want.flags.cout), 18'(res.flags.cout));
				compare_field("res.flags.ovf", 18'(want.flags.ovf), 18'(res.flags.ovf));
				compare_field("res.flags.zero", 18'(want.flags.zero), 18'(res.flags.zero));
				compare_field("res.flags.neg", 18'(want.flags.neg), 18'(res.flags.neg));
			end
		end
		// Push after the pop so back-to-back operations line up
		if (!rst && exp_valid)
			exp_q.push_back(exp_res);
		if (end_check && exp_q.size() != 0) begin
			$display("Error at %0t ns: %0d expected results never appeared on res_valid",
				$time, exp_q.size());
			prot += exp_q.size();
			exp_q.delete();
		end
		mismatch_count <= mism;
		protocol_count <= prot;
		checked_count  <= seen;
	end

endmodule

`default_nettype wire

//--- tests/ling_alu_tb.sv
// Directed rows assume a zero accumulator after reset; random rows come from an LCG with seed 90
`default_nettype none

module ling_alu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_RANDOM = 64;

	typedef struct packed {
		ling_pkg::opcode_t          op;
		logic [ling_pkg::WIDTH-1:0] a;
		logic [ling_pkg::WIDTH-1:0] b;
		logic                       cin;
		ling_pkg::result_t          want;
		// Idle cycles after this row
		logic [1:0]                 gap;
	} row_t;

	logic                       clk;
	logic                       rst;
	logic                       op_valid;
	ling_pkg::opcode_t          op;
	logic [ling_pkg::WIDTH-1:0] a;
	logic [ling_pkg::WIDTH-1:0] b;
	logic                       cin;
	logic                       res_valid;
	ling_pkg::result_t          res;
	logic                       exp_valid;
	ling_pkg::result_t          exp_res;
	logic                       end_check;
	int                         mismatch_count;
	int                         protocol_count;
	int                         checked_count;

	row_t                       rows[$];
	int                         issued = 0;
	int                         cycle_count = 0;
	int                         cycle_limit = 0;
	logic [ling_pkg::WIDTH-1:0] model_acc = '0;
	logic [31:0]                lcg_state = 32'd90;

	ling_alu_top ling_alu_top_i (
		.clk       (clk),
		.rst       (rst),
		.op_valid  (op_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.cin       (cin),
		.res_valid (res_valid),
		.res       (res)
	);

	ling_alu_checker chk_i (
		.clk            (clk),
		.rst            (rst),
		.exp_valid      (exp_valid),
		.exp_res        (exp_res),
		.res_valid      (res_valid),
		.res            (res),
		.end_check      (end_check),
		.mismatch_count (mismatch_count),
		.protocol_count (protocol_count),
		.checked_count  (checked_count)
	);

	bind ling_alu_ctrl ling_alu_props props_i (
		.clk       (clk),
		.rst       (rst),
		.op_valid  (op_valid),
		.res_valid (res_valid),
		.res       (res)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Reference arithmetic on a 19-bit sum
	function automatic ling_pkg::result_t model_result(input ling_pkg::opcode_t o,
			input logic [17:0] x, input logic [17:0] y, input logic c, input logic [17:0] acc_now);
		logic [17:0]       opa;
		logic [17:0]       opb;
		logic              ci;
		logic [18:0]       full;
		ling_pkg::result_t r;
		case (o)
			ling_pkg::OP_ADD: begin
				opa = x;
				opb = y;
				ci  = c;
			end
			ling_pkg::OP_SUB: begin
				opa = x;
				opb = ~y;
				ci  = 1'b1;
			end
			ling_pkg::OP_ACC: begin
				opa = acc_now;
				opb = y;
				ci  = 1'b0;
			end
			default: begin
				opa = '0;
				opb = '0;
				ci  = 1'b0;
			end
		endcase
		full = {1'b0, opa} + {1'b0, opb} + {18'b0, ci};
		r.sum        = full[17:0];
		r.flags.cout = full[18];
		r.flags.ovf  = (opa[17] == opb[17]) && (full[17] != opa[17]);
		r.flags.zero = (full[17:0] == 18'd0);
		r.flags.neg  = full[17];
		return r;
	endfunction

	task automatic add_row(input ling_pkg::opcode_t o, input logic [17:0] x, input logic [17:0] y,
			input logic c, input logic [17:0] s, input ling_pkg::flags_t f, input logic [1:0] g);
		row_t r;
		r.op   = o;
		r.a    = x;
		r.b    = y;
		r.cin  = c;
		r.want = '{sum: s, flags: f};
		r.gap  = g;
		rows.push_back(r);
	endtask

	task automatic apply_row(input row_t r);
		@(posedge clk);
		op_valid  <= 1'b1;
		op        <= r.op;
		a         <= r.a;
		b         <= r.b;
		cin       <= r.cin;
		exp_valid <= 1'b1;
		exp_res   <= r.want;
		issued++;
		// Shadow accumulator follows the expected sums
		if (r.op == ling_pkg::OP_ACC)
			model_acc = r.want.sum;
		else if (r.op == ling_pkg::OP_CLR)
			model_acc = '0;
		repeat (r.gap) begin
			@(posedge clk);
			op_valid  <= 1'b0;
			exp_valid <= 1'b0;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, %0d of %0d results seen",
				cycle_count, checked_count, issued);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		row_t r;
		rst       <= 1'b1;
		op_valid  <= 1'b0;
		op        <= ling_pkg::OP_ADD;
		a         <= '0;
		b         <= '0;
		cin       <= 1'b0;
		exp_valid <= 1'b0;
		exp_res   <= '0;
		end_check <= 1'b0;

		// Flags column is {cout, ovf, zero, neg}
		add_row(ling_pkg::OP_ADD, 18'h3FFFF, 18'h00000, 1'b1, 18'h00000, 4'b1010, 2'd0);
		add_row(ling_pkg::OP_ADD, 18'h3FFFF, 18'h00001, 1'b0, 18'h00000, 4'b1010, 2'd0);
		add_row(ling_pkg::OP_ADD, 18'h3FFFF, 18'h3FFFF, 1'b1, 18'h3FFFF, 4'b1001, 2'd0);
		add_row(ling_pkg::OP_ADD, 18'h15555, 18'h0AAAA, 1'b1, 18'h20000, 4'b0101, 2'd0);
		add_row(ling_pkg::OP_ADD, 18'h00000, 18'h00000, 1'b0, 18'h00000, 4'b0010, 2'd2);
		add_row(ling_pkg::OP_SUB, 18'h12345, 18'h12345, 1'b0, 18'h00000, 4'b1010, 2'd0);
		add_row(ling_pkg::OP_SUB, 18'h00005, 18'h00007, 1'b1, 18'h3FFFE, 4'b0001, 2'd0);
		add_row(ling_pkg::OP_SUB, 18'h1FFFF, 18'h3FFFF, 1'b0, 18'h20000, 4'b0101, 2'd0);
		add_row(ling_pkg::OP_SUB, 18'h20000, 18'h00001, 1'b1, 18'h1FFFF, 4'b1100, 2'd0);
		add_row(ling_pkg::OP_SUB, 18'h00010, 18'h00003, 1'b0, 18'h0000D, 4'b1000, 2'd3);
		add_row(ling_pkg::OP_ADD, 18'h10000, 18'h10000, 1'b0, 18'h20000, 4'b0101, 2'd0);
		add_row(ling_pkg::OP_ADD, 18'h20000, 18'h20000, 1'b0, 18'h00000, 4'b1110, 2'd0);
		add_row(ling_pkg::OP_ADD, 18'h30000, 18'h28000, 1'b0, 18'h18000, 4'b1100, 2'd0);
		add_row(ling_pkg::OP_ADD, 18'h1FFFF, 18'h20000, 1'b1, 18'h00000, 4'b1010, 2'd1);
		// Running total from back-to-back accumulates
		add_row(ling_pkg::OP_CLR, 18'h12345, 18'h00111, 1'b1, 18'h00000, 4'b0010, 2'd0);
		add_row(ling_pkg::OP_ACC, 18'h3FFFF, 18'h00100, 1'b1, 18'h00100, 4'b0000, 2'd0);
		add_row(ling_pkg::OP_ACC, 18'h00000, 18'h00200, 1'b0, 18'h00300, 4'b0000, 2'd0);
		add_row(ling_pkg::OP_ACC, 18'h3FFFF, 18'h3FD00, 1'b1, 18'h00000, 4'b1010, 2'd0);
		add_row(ling_pkg::OP_ACC, 18'h00000, 18'h1FFFF, 1'b0, 18'h1FFFF, 4'b0000, 2'd0);
		add_row(ling_pkg::OP_ACC, 18'h00000, 18'h00001, 1'b0, 18'h20000, 4'b0101, 2'd0);
		add_row(ling_pkg::OP_CLR, 18'h00000, 18'h00000, 1'b0, 18'h00000, 4'b0010, 2'd1);
		add_row(ling_pkg::OP_ACC, 18'h00000, 18'h00005, 1'b1, 18'h00005, 4'b0000, 2'd2);
		add_row(ling_pkg::OP_ADD, 18'h0ABCD, 18'h01234, 1'b1, 18'h0BE02, 4'b0000, 2'd0);
		cycle_limit = 2 * (rows.size() + NUM_RANDOM) + 50;

		repeat (3) @(posedge clk);
		rst <= 1'b0;

		foreach (rows[i])
			apply_row(rows[i]);

		for (int n = 0; n < NUM_RANDOM; n++) begin
			lcg_state = lcg_next(lcg_state);
			r.op      = ling_pkg::opcode_t'(lcg_state[31:30]);
			r.cin     = lcg_state[29];
			r.gap     = {1'b0, lcg_state[28]};
			lcg_state = lcg_next(lcg_state);
			r.a       = lcg_state[31:14];
			lcg_state = lcg_next(lcg_state);
			r.b       = lcg_state[31:14];
			r.want    = model_result(r.op, r.a, r.b, r.cin, model_acc);
			apply_row(r);
		end

		@(posedge clk);
		op_valid  <= 1'b0;
		exp_valid <= 1'b0;
		while (checked_count < issued)
			@(posedge clk);
		end_check <= 1'b1;
		@(posedge clk);
		end_check <= 1'b0;
		@(negedge clk);

		$display("Errors: %0d mismatches, %0d protocol errors", mismatch_count, protocol_count);
		if (mismatch_count == 0 && protocol_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
source/ling_pkg.sv
source/ling_operand_prep.sv
source/ling_prefix_tree.sv
source/ling_post_compute.sv
source/ling_alu_ctrl.sv
source/ling_alu_top.sv
tests/ling_alu_props.sv
tests/ling_alu_checker.sv
tests/ling_alu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module ling_alu_tb \
	-f flist.f > build.log 2>&1 \
	&& ./obj_dir/Vling_alu_tb > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "all tests passed" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }
